/* ldpc_consts.svh */
/*
 * LDPC check-node constants
 * Datapath widths, pipeline latencies and the control register map
 */

`ifndef LDPC_CONSTS_SVH
`define LDPC_CONSTS_SVH

// LLR and magnitude width in bits
`define LDPC_LLR_W       8

// Inputs per check row
`define LDPC_DEGREE      6

// Minimum finder and full check-node latency in cycles
`define LDPC_MIN_LAT     3
`define LDPC_CN_LAT      13

// Byte addresses of the control registers
`define LDPC_REG_OFFSET  32'h0000_0000
`define LDPC_REG_ROWS    32'h0000_0004

`endif

/* ldpc_types_pkg.sv */
/*
 * LDPC datapath types
 * LLRs, magnitudes, minimum locations and check rows
 */

`default_nettype none

`include "ldpc_consts.svh"

package ldpc_types_pkg;

    typedef logic signed [`LDPC_LLR_W-1:0] llr_t;
    typedef logic [`LDPC_LLR_W-1:0] mag_t;

    // One-hot position of the minimum within a row
    typedef logic [`LDPC_DEGREE-1:0] loc_t;

    typedef struct packed {
        llr_t a0;
        llr_t a1;
        llr_t a2;
        llr_t a3;
        llr_t a4;
        llr_t a5;
    } llr_row_t;

    // Minimum finder input, eight entries with entry 0 in the low bits
    typedef mag_t [7:0] mag_vec_t;

endpackage

`default_nettype wire

/* ldpc_axil_pkg.sv */
/*
 * AXI4-Lite types for the check-node control port
 */

`default_nettype none

package ldpc_axil_pkg;

    typedef logic [31:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [1:0]  axil_resp_t;

    localparam axil_resp_t AXIL_OKAY   = 2'd0;
    localparam axil_resp_t AXIL_SLVERR = 2'd2;

    // Master to slave
    typedef struct packed {
        axil_addr_t awaddr;
        logic       awvalid;
        axil_data_t wdata;
        logic [3:0] wstrb;
        logic       wvalid;
        logic       bready;
        axil_addr_t araddr;
        logic       arvalid;
        logic       rready;
    } axil_req_t;

    // Slave to master
    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        axil_resp_t bresp;
        logic       arready;
        logic       rvalid;
        axil_data_t rdata;
        axil_resp_t rresp;
    } axil_rsp_t;

endpackage

`default_nettype wire

/* ldpc_minimum.sv */
/*
 * Pipelined minimum finder
 * Three registered compare levels reduce eight magnitudes to the smallest
 * one and its one-hot position, lowest index winning on a tie
 */

`timescale 1ns/10ps
`default_nettype none

module ldpc_minimum #(
    parameter int WIDTH = 8
) (
    input  wire logic                  i_clock,
    input  wire logic                  i_reset,
    input  wire logic [7:0][WIDTH-1:0] i_in_data,
    output      logic [WIDTH-1:0]      o_out_data,
    output      logic [7:0]            o_min_location
);

logic [WIDTH-1:0] val_l1 [4];
logic [7:0]       loc_l1 [4];
logic [WIDTH-1:0] val_l2 [2];
logic [7:0]       loc_l2 [2];
logic [3:0]       odd_l1;
logic [1:0]       odd_l2;
logic             odd_l3;

// Odd entry wins only when strictly smaller
always_comb begin
    for (int k = 0; k < 4; k++) begin
        odd_l1[k] = i_in_data[2*k+1] < i_in_data[2*k];
    end
    for (int k = 0; k < 2; k++) begin
        odd_l2[k] = val_l1[2*k+1] < val_l1[2*k];
    end
    odd_l3 = val_l2[1] < val_l2[0];
end

always_ff @(posedge i_clock) begin
    for (int k = 0; k < 4; k++) begin
        val_l1[k] <= odd_l1[k] ? i_in_data[2*k+1] : i_in_data[2*k];
    end
    for (int k = 0; k < 2; k++) begin
        val_l2[k] <= odd_l2[k] ? val_l1[2*k+1] : val_l1[2*k];
    end
    o_out_data <= odd_l3 ? val_l2[1] : val_l2[0];
end

// Position tracks the winning value through each level
always_ff @(posedge i_clock) begin
    if (i_reset) begin
        loc_l1         <= '{default: '0};
        loc_l2         <= '{default: '0};
        o_min_location <= '0;
    end else begin
        for (int k = 0; k < 4; k++) begin
            loc_l1[k] <= 8'b1 << (2*k + odd_l1[k]);
        end
        for (int k = 0; k < 2; k++) begin
            loc_l2[k] <= odd_l2[k] ? loc_l1[2*k+1] : loc_l1[2*k];
        end
        o_min_location <= odd_l3 ? loc_l2[1] : loc_l2[0];
    end
end

endmodule

`default_nettype wire

/* ldpc_minsigner.sv */
/*
 * Min-sign pipeline for one check row
 * Finds the two smallest magnitudes and the sign parity, then builds the
 * offset-corrected extrinsic LLRs, 13 cycles from input to output
 */

`timescale 1ns/10ps
`default_nettype none

`include "ldpc_consts.svh"

module ldpc_minsigner (
    input  wire logic                     i_clock,
    input  wire logic                     i_reset,
    input  wire ldpc_types_pkg::llr_row_t i_row,
    input  wire logic                     i_valid,
    input  wire ldpc_types_pkg::mag_t     i_offset,
    output      ldpc_types_pkg::llr_row_t o_row,
    output      logic                     o_valid
);

ldpc_types_pkg::llr_t                    in_llr [`LDPC_DEGREE];
ldpc_types_pkg::mag_t [`LDPC_DEGREE-1:0] mag_s [`LDPC_MIN_LAT+1];
logic [`LDPC_DEGREE-1:0]                 sign_s [11];
ldpc_types_pkg::mag_vec_t                first_in;
ldpc_types_pkg::mag_t                    first_min_s3;
logic [7:0]                              first_loc_s3;
ldpc_types_pkg::mag_t [`LDPC_DEGREE-1:0] excl_s4;
ldpc_types_pkg::mag_t                    first_min_s [4:11];
ldpc_types_pkg::loc_t                    loc_s [4:11];
ldpc_types_pkg::mag_vec_t                second_in;
ldpc_types_pkg::mag_t                    second_min_s7;
ldpc_types_pkg::mag_t                    second_min_s [8:11];
logic                                    par_lo_s9;
logic                                    par_hi_s9;
logic                                    parity_s10;
logic [`LDPC_DEGREE-1:0]                 out_sign_s11;
ldpc_types_pkg::mag_t                    sel_mag [`LDPC_DEGREE];
ldpc_types_pkg::mag_t                    cor_mag [`LDPC_DEGREE];
ldpc_types_pkg::llr_t                    out_llr [`LDPC_DEGREE];
logic [`LDPC_CN_LAT-2:0]                 valid_sr;

assign in_llr[0] = i_row.a0;
assign in_llr[1] = i_row.a1;
assign in_llr[2] = i_row.a2;
assign in_llr[3] = i_row.a3;
assign in_llr[4] = i_row.a4;
assign in_llr[5] = i_row.a5;

// Stage 0 sign/magnitude split, then delay lines
always_ff @(posedge i_clock) begin
    for (int i = 0; i < `LDPC_DEGREE; i++) begin
        mag_s[0][i]  <= in_llr[i][`LDPC_LLR_W-1] ? ldpc_types_pkg::mag_t'(-in_llr[i])
                                                  : ldpc_types_pkg::mag_t'(in_llr[i]);
        sign_s[0][i] <= in_llr[i][`LDPC_LLR_W-1];
    end
    for (int k = 1; k <= `LDPC_MIN_LAT; k++) begin
        mag_s[k] <= mag_s[k-1];
    end
    for (int k = 1; k < 11; k++) begin
        sign_s[k] <= sign_s[k-1];
    end
end

assign first_in = {{(2*`LDPC_LLR_W){1'b1}}, mag_s[0]};

ldpc_minimum #(
    .WIDTH (`LDPC_LLR_W)
) u_first_min (
    .i_clock        (i_clock),
    .i_reset        (i_reset),
    .i_in_data      (first_in),
    .o_out_data     (first_min_s3),
    .o_min_location (first_loc_s3)
);

// Knock out the first minimum, min - min - 1 wraps to all ones
always_ff @(posedge i_clock) begin
    for (int i = 0; i < `LDPC_DEGREE; i++) begin
        excl_s4[i] <= first_loc_s3[i] ? mag_s[`LDPC_MIN_LAT][i] - first_min_s3 - 1'b1
                                      : mag_s[`LDPC_MIN_LAT][i];
    end
    first_min_s[4] <= first_min_s3;
    loc_s[4]       <= first_loc_s3[`LDPC_DEGREE-1:0];
    for (int k = 5; k <= 11; k++) begin
        first_min_s[k] <= first_min_s[k-1];
        loc_s[k]       <= loc_s[k-1];
    end
end

assign second_in = {{(2*`LDPC_LLR_W){1'b1}}, excl_s4};

ldpc_minimum #(
    .WIDTH (`LDPC_LLR_W)
) u_second_min (
    .i_clock        (i_clock),
    .i_reset        (i_reset),
    .i_in_data      (second_in),
    .o_out_data     (second_min_s7),
    .o_min_location ()
);

// Sign parity tree, aligned to stage 11
always_ff @(posedge i_clock) begin
    second_min_s[8] <= second_min_s7;
    for (int k = 9; k <= 11; k++) begin
        second_min_s[k] <= second_min_s[k-1];
    end
    par_lo_s9    <= ^sign_s[8][2:0];
    par_hi_s9    <= ^sign_s[8][5:3];
    parity_s10   <= par_lo_s9 ^ par_hi_s9;
    out_sign_s11 <= {`LDPC_DEGREE{parity_s10}} ^ sign_s[10];
end

always_comb begin
    for (int i = 0; i < `LDPC_DEGREE; i++) begin
        sel_mag[i] = loc_s[11][i] ? second_min_s[11] : first_min_s[11];
        cor_mag[i] = (sel_mag[i] > i_offset) ? sel_mag[i] - i_offset : '0;
        out_llr[i] = out_sign_s11[i] ? -ldpc_types_pkg::llr_t'(cor_mag[i])
                                     : ldpc_types_pkg::llr_t'(cor_mag[i]);
    end
end

always_ff @(posedge i_clock) begin
    o_row.a0 <= out_llr[0];
    o_row.a1 <= out_llr[1];
    o_row.a2 <= out_llr[2];
    o_row.a3 <= out_llr[3];
    o_row.a4 <= out_llr[4];
    o_row.a5 <= out_llr[5];
end

always_ff @(posedge i_clock) begin
    if (i_reset) begin
        valid_sr <= '0;
        o_valid  <= 1'b0;
    end else begin
        valid_sr <= {valid_sr[`LDPC_CN_LAT-3:0], i_valid};
        o_valid  <= valid_sr[`LDPC_CN_LAT-2];
    end
end

endmodule

`default_nettype wire

/* ldpc_ctrl_regs.sv */
/*
 * Check-node control registers on AXI4-Lite
 * Min-sum offset at 0x0, read-only count of finished rows at 0x4
 */

`timescale 1ns/10ps
`default_nettype none

`include "ldpc_consts.svh"

module ldpc_ctrl_regs (
    input  wire logic                     i_clock,
    input  wire logic                     i_reset,
    input  wire ldpc_axil_pkg::axil_req_t i_axil,
    output      ldpc_axil_pkg::axil_rsp_t o_axil,
    input  wire logic                     i_row_done,
    output      ldpc_types_pkg::mag_t     o_offset
);

typedef enum logic {IDLE, RESP} resp_state_t;

resp_state_t               wr_state;
resp_state_t               rd_state;
logic                      aw_ready;
logic                      ar_ready;
logic                      b_valid;
logic                      r_valid;
ldpc_axil_pkg::axil_resp_t b_resp;
ldpc_axil_pkg::axil_resp_t r_resp;
ldpc_axil_pkg::axil_data_t r_data;
ldpc_axil_pkg::axil_data_t row_count;
ldpc_types_pkg::mag_t      offset;

// Write channel, address and data accepted together
always_ff @(posedge i_clock) begin
    if (i_reset) begin
        wr_state <= IDLE;
        aw_ready <= 1'b0;
        b_valid  <= 1'b0;
        b_resp   <= ldpc_axil_pkg::AXIL_OKAY;
        offset   <= '0;
    end else begin
        case (wr_state)
            IDLE: begin
                if (aw_ready) begin
                    aw_ready <= 1'b0;
                    b_valid  <= 1'b1;
                    wr_state <= RESP;
                    if (i_axil.awaddr == `LDPC_REG_OFFSET) begin
                        b_resp <= ldpc_axil_pkg::AXIL_OKAY;
                        if (i_axil.wstrb[0]) begin
                            offset <= i_axil.wdata[`LDPC_LLR_W-1:0];
                        end
                    end else begin
                        b_resp <= ldpc_axil_pkg::AXIL_SLVERR;
                    end
                end else if (i_axil.awvalid && i_axil.wvalid) begin
                    aw_ready <= 1'b1;
                end
            end
            RESP: begin
                if (i_axil.bready) begin
                    b_valid  <= 1'b0;
                    wr_state <= IDLE;
                end
            end
        endcase
    end
end

always_ff @(posedge i_clock) begin
    if (i_reset) begin
        rd_state <= IDLE;
        ar_ready <= 1'b0;
        r_valid  <= 1'b0;
        r_resp   <= ldpc_axil_pkg::AXIL_OKAY;
        r_data   <= '0;
    end else begin
        case (rd_state)
            IDLE: begin
                if (ar_ready) begin
                    ar_ready <= 1'b0;
                    r_valid  <= 1'b1;
                    rd_state <= RESP;
                    r_resp   <= ldpc_axil_pkg::AXIL_OKAY;
                    case (i_axil.araddr)
                        `LDPC_REG_OFFSET: r_data <= ldpc_axil_pkg::axil_data_t'(offset);
                        `LDPC_REG_ROWS:   r_data <= row_count;
                        default: begin
                            r_data <= '0;
                            r_resp <= ldpc_axil_pkg::AXIL_SLVERR;
                        end
                    endcase
                end else if (i_axil.arvalid) begin
                    ar_ready <= 1'b1;
                end
            end
            RESP: begin
                if (i_axil.rready) begin
                    r_valid  <= 1'b0;
                    rd_state <= IDLE;
                end
            end
        endcase
    end
end

// Wraps at 2^32
always_ff @(posedge i_clock) begin
    if (i_reset) begin
        row_count <= '0;
    end else if (i_row_done) begin
        row_count <= row_count + 1'b1;
    end
end

always_comb begin
    o_axil.awready = aw_ready;
    o_axil.wready  = aw_ready;
    o_axil.bvalid  = b_valid;
    o_axil.bresp   = b_resp;
    o_axil.arready = ar_ready;
    o_axil.rvalid  = r_valid;
    o_axil.rdata   = r_data;
    o_axil.rresp   = r_resp;
end

assign o_offset = offset;

endmodule

`default_nettype wire

/* ldpc_check_node.sv */
/*
 * LDPC check-node unit top level
 * Offset min-sum pipeline with its AXI4-Lite control registers
 */

`timescale 1ns/10ps
`default_nettype none

module ldpc_check_node (
    input  wire logic                     i_clock,
    input  wire logic                     i_reset,
    input  wire ldpc_types_pkg::llr_row_t i_row,
    input  wire logic                     i_valid,
    output      ldpc_types_pkg::llr_row_t o_row,
    output      logic                     o_valid,
    input  wire ldpc_axil_pkg::axil_req_t i_axil,
    output      ldpc_axil_pkg::axil_rsp_t o_axil
);

ldpc_types_pkg::mag_t offset;

ldpc_ctrl_regs u_ctrl_regs (
    .i_clock    (i_clock),
    .i_reset    (i_reset),
    .i_axil     (i_axil),
    .o_axil     (o_axil),
    .i_row_done (o_valid),
    .o_offset   (offset)
);

// Offset is sampled in the output stage
ldpc_minsigner u_minsigner (
    .i_clock  (i_clock),
    .i_reset  (i_reset),
    .i_row    (i_row),
    .i_valid  (i_valid),
    .i_offset (offset),
    .o_row    (o_row),
    .o_valid  (o_valid)
);

endmodule

`default_nettype wire

/* tb_ldpc_check_node.sv */
/*
 * Testbench for the LDPC check-node unit
 * Random and corner rows against an offset min-sum model, plus register access
 */

`timescale 1ns/10ps
`default_nettype none

`include "ldpc_consts.svh"

module tb_ldpc_check_node;

localparam int WAIT_LIMIT = 200;

logic                     i_clock;
logic                     i_reset;
ldpc_types_pkg::llr_row_t i_row;
logic                     i_valid;
ldpc_types_pkg::llr_row_t o_row;
logic                     o_valid;
ldpc_axil_pkg::axil_req_t axil_req;
ldpc_axil_pkg::axil_rsp_t axil_rsp;

int          cycle = 0;
int          mismatches = 0;
int          failures = 0;
int          rows_sent = 0;
int          offset = 0;
int unsigned seed;
logic [47:0] exp_rows [$];
int          exp_cycles [$];
logic [47:0] done_row;

ldpc_check_node UUT (
    .i_clock (i_clock),
    .i_reset (i_reset),
    .i_row   (i_row),
    .i_valid (i_valid),
    .o_row   (o_row),
    .o_valid (o_valid),
    .i_axil  (axil_req),
    .o_axil  (axil_rsp)
);

initial begin
    i_clock = 1'b0;
    forever #50 i_clock = ~i_clock;
end

always @(posedge i_clock) begin
    cycle <= cycle + 1;
end

// Field i of a row, a0 sits in the top byte
function automatic logic [7:0] field(input logic [47:0] r, input int i);
    return r[(5-i)*8 +: 8];
endfunction

function automatic logic [47:0] make_row(input int v0, input int v1, input int v2,
                                         input int v3, input int v4, input int v5);
    return {v0[7:0], v1[7:0], v2[7:0], v3[7:0], v4[7:0], v5[7:0]};
endfunction

function automatic logic [47:0] random_row();
    logic [47:0] r;
    int          v;
    for (int i = 0; i < 6; i++) begin
        v = int'($urandom % 255) - 127;
        r[(5-i)*8 +: 8] = v[7:0];
    end
    return r;
endfunction

// Smallest magnitude and sign product over the other five inputs
function automatic logic [47:0] model_row(input logic [47:0] r, input int off);
    int          mag [6];
    logic        neg [6];
    int          m;
    int          v;
    logic        s;
    logic [47:0] res;
    for (int i = 0; i < 6; i++) begin
        v = $signed(field(r, i));
        neg[i] = v < 0;
        mag[i] = (v < 0) ? -v : v;
    end
    for (int i = 0; i < 6; i++) begin
        m = 1000;
        s = 1'b0;
        for (int j = 0; j < 6; j++) begin
            if (j != i) begin
                m = (mag[j] < m) ? mag[j] : m;
                s = s ^ neg[j];
            end
        end
        m = (m > off) ? m - off : 0;
        v = s ? -m : m;
        res[(5-i)*8 +: 8] = v[7:0];
    end
    return res;
endfunction

task automatic expect_equal(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    assert (got === exp) else begin
        $display("MISMATCH %s: got %h expected %h", name, got, exp);
        mismatches++;
    end
endtask

task automatic stop_on_timeout(input string what);
    failures++;
    $display("Timeout while waiting for %s", what);
    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    $display("Some tests failed");
    $finish;
endtask

// Compare on the falling edge, away from DUT updates
always @(negedge i_clock) begin
    if (!i_reset) begin
        if (exp_cycles.size() > 0 && exp_cycles[0] == cycle) begin
            done_row = exp_rows.pop_front();
            exp_cycles.delete(0);
            expect_equal("o_valid", o_valid, 1'b1);
            for (int i = 0; i < 6; i++) begin
                assert (field(o_row, i) === field(done_row, i)) else begin
                    $display("MISMATCH o_row.a%0d: got %h expected %h",
                             i, field(o_row, i), field(done_row, i));
                    mismatches++;
                end
            end
        end else begin
            expect_equal("o_valid", o_valid, 1'b0);
        end
    end
end

task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                          output logic [1:0] resp);
    int n;
    @(posedge i_clock);
    #1;
    axil_req.awaddr  = addr;
    axil_req.awvalid = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = 4'hf;
    axil_req.wvalid  = 1'b1;
    axil_req.bready  = 1'b1;
    n = 0;
    while (!axil_rsp.awready) begin
        if (n == WAIT_LIMIT) stop_on_timeout("awready");
        @(posedge i_clock);
        #1;
        n++;
    end
    expect_equal("wready", axil_rsp.wready, 1'b1);
    // Accepted on the next edge
    @(posedge i_clock);
    #1;
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    n = 0;
    while (!axil_rsp.bvalid) begin
        if (n == WAIT_LIMIT) stop_on_timeout("bvalid");
        @(posedge i_clock);
        #1;
        n++;
    end
    resp = axil_rsp.bresp;
    @(posedge i_clock);
    #1;
    axil_req.bready = 1'b0;
endtask

task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
                         output logic [1:0] resp);
    int n;
    @(posedge i_clock);
    #1;
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    axil_req.rready  = 1'b1;
    n = 0;
    while (!axil_rsp.arready) begin
        if (n == WAIT_LIMIT) stop_on_timeout("arready");
        @(posedge i_clock);
        #1;
        n++;
    end
    @(posedge i_clock);
    #1;
    axil_req.arvalid = 1'b0;
    n = 0;
    while (!axil_rsp.rvalid) begin
        if (n == WAIT_LIMIT) stop_on_timeout("rvalid");
        @(posedge i_clock);
        #1;
        n++;
    end
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    @(posedge i_clock);
    #1;
    axil_req.rready = 1'b0;
endtask

task automatic expect_register(input logic [31:0] addr, input logic [31:0] exp,
                               input logic [1:0] exp_resp);
    logic [31:0] data;
    logic [1:0]  resp;
    axil_read(addr, data, resp);
    expect_equal("rdata", data, exp);
    expect_equal("rresp", resp, exp_resp);
endtask

task automatic set_offset(input int value);
    logic [1:0] resp;
    axil_write(`LDPC_REG_OFFSET, value, resp);
    expect_equal("bresp", resp, ldpc_axil_pkg::AXIL_OKAY);
    offset = value;
    expect_register(`LDPC_REG_OFFSET, value, ldpc_axil_pkg::AXIL_OKAY);
endtask

task automatic send_row(input logic [47:0] row);
    @(posedge i_clock);
    #1;
    i_row   = row;
    i_valid = 1'b1;
    exp_rows.push_back(model_row(row, offset));
    exp_cycles.push_back(cycle + `LDPC_CN_LAT);
    rows_sent++;
endtask

task automatic idle_cycles(input int n);
    repeat (n) begin
        @(posedge i_clock);
        #1;
        i_valid = 1'b0;
    end
endtask

task automatic wait_drain();
    int n;
    idle_cycles(1);
    n = 0;
    while (exp_rows.size() > 0) begin
        if (n == WAIT_LIMIT) stop_on_timeout("the output rows");
        @(posedge i_clock);
        n++;
    end
    idle_cycles(2);
endtask

initial begin
    logic [1:0] resp;
    seed     = 32'h58cc_0d63;
    void'($urandom(seed));
    i_reset  = 1'b1;
    i_valid  = 1'b0;
    i_row    = '0;
    axil_req = '0;
    repeat (16) @(posedge i_clock);
    #1;
    i_reset = 1'b0;

    expect_equal("o_valid", o_valid, 1'b0);
    expect_equal("bvalid", axil_rsp.bvalid, 1'b0);
    expect_equal("rvalid", axil_rsp.rvalid, 1'b0);
    expect_register(`LDPC_REG_OFFSET, 32'h0, ldpc_axil_pkg::AXIL_OKAY);
    expect_register(`LDPC_REG_ROWS, 32'h0, ldpc_axil_pkg::AXIL_OKAY);

    repeat (24) begin
        send_row(random_row());
        idle_cycles(1 + $urandom % 3);
    end
    wait_drain();

    // Ties, zeros, uniform signs and full-scale values
    send_row(make_row(5, -5, 5, 9, 20, -30));
    send_row(make_row(3, 3, 100, -100, 50, 60));
    send_row(make_row(0, 10, -20, 30, 0, 7));
    send_row(make_row(0, 0, 0, 0, 0, 0));
    send_row(make_row(-1, -2, -3, -4, -5, -6));
    send_row(make_row(1, 2, 3, 4, 5, 6));
    send_row(make_row(127, -127, 127, -127, 127, -127));
    send_row(make_row(-127, -127, -127, -127, -127, -127));
    send_row(make_row(127, 1, -127, 64, -64, 127));
    wait_drain();

    set_offset(2);
    repeat (20) send_row(random_row());
    wait_drain();
    set_offset(40);
    repeat (20) send_row(random_row());
    wait_drain();

    repeat (16) send_row(random_row());
    repeat (24) begin
        send_row(random_row());
        idle_cycles($urandom % 4);
    end
    wait_drain();
    expect_register(`LDPC_REG_ROWS, rows_sent, ldpc_axil_pkg::AXIL_OKAY);

    expect_register(32'h8, 32'h0, ldpc_axil_pkg::AXIL_SLVERR);
    axil_write(32'h8, 32'h55, resp);
    expect_equal("bresp", resp, ldpc_axil_pkg::AXIL_SLVERR);
    axil_write(`LDPC_REG_ROWS, 32'h1234, resp);
    expect_equal("bresp", resp, ldpc_axil_pkg::AXIL_SLVERR);
    expect_register(`LDPC_REG_ROWS, rows_sent, ldpc_axil_pkg::AXIL_OKAY);
    expect_register(`LDPC_REG_OFFSET, 40, ldpc_axil_pkg::AXIL_OKAY);

    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
        $display("All tests passed");
    end else begin
        $display("Some tests failed");
    end
    $finish;
end

endmodule

`default_nettype wire

/* ldpc_check_node.f */
+incdir+.
ldpc_types_pkg.sv
ldpc_axil_pkg.sv
ldpc_minimum.sv
ldpc_minsigner.sv
ldpc_ctrl_regs.sv
ldpc_check_node.sv
tb_ldpc_check_node.sv

/* Bender.yml */
package:
  name: ldpc_check_node

export_include_dirs:
  - .

sources:
  - ldpc_types_pkg.sv
  - ldpc_axil_pkg.sv
  - ldpc_minimum.sv
  - ldpc_minsigner.sv
  - ldpc_ctrl_regs.sv
  - ldpc_check_node.sv
  - target: test
    files:
      - tb_ldpc_check_node.sv
